// File: Bender.yml
package:
  name: mm_accel

sources:
  - include_dirs:
      - source
    files:
      - source/mm_pkg.sv
      - source/mm_beat_if.sv
      - source/mm_control_regs.sv
      - source/mm_read_dma.sv
      - source/mm_write_dma.sv
      - source/mm_mac_engine.sv
      - source/mm_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mm_clock_gen.sv
      - tb/mm_assertions.sv
      - tb/mm_tb.sv

// File: compile.f
+incdir+source
source/mm_pkg.sv
source/mm_beat_if.sv
source/mm_control_regs.sv
source/mm_read_dma.sv
source/mm_write_dma.sv
source/mm_mac_engine.sv
source/mm_top.sv
tb/mm_clock_gen.sv
tb/mm_assertions.sv
tb/mm_tb.sv

// File: source/mm_beat_if.sv
`default_nettype none

// Row-beat stream that moves a beat when valid and ready are both high
interface mm_beat_if #(
    parameter type payload_t = logic [7:0]
);

    logic     valid;
    logic     ready;
    payload_t data;
    logic     last;

    modport source (output valid, output data, output last, input ready);
    modport sink   (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// File: source/mm_config.svh
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// Every burst moves one matrix of this many rows
`define MM_DIM 16

// Memory side address width
`define MM_ADDR_W 32

// AXI-Lite register window
`define MM_REG_ADDR_W 6

// Register byte offsets
`define MM_REG_CTRL   6'h00
`define MM_REG_A_ADDR 6'h04
`define MM_REG_B_ADDR 6'h08
`define MM_REG_C_ADDR 6'h0C

`endif

// File: source/mm_control_regs.sv
`default_nettype none

`include "mm_config.svh"

module mm_control_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s_awvalid,
    input  logic [`MM_REG_ADDR_W-1:0] s_awaddr,
    output logic                      s_awready,
    input  logic                      s_wvalid,
    input  logic [31:0]               s_wdata,
    output logic                      s_wready,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic                      s_arvalid,
    input  logic [`MM_REG_ADDR_W-1:0] s_araddr,
    output logic                      s_arready,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic [31:0]               s_rdata,
    input  logic                      a_done,
    input  logic                      b_done,
    input  logic                      c_done,
    output logic                      go,
    output logic [`MM_ADDR_W-1:0]     a_addr,
    output logic [`MM_ADDR_W-1:0]     b_addr,
    output logic [`MM_ADDR_W-1:0]     c_addr,
    output logic                      interrupt
);

    logic               wr_en;
    logic               rd_en;
    logic               start_reg;
    logic               start_q;
    logic               a_seen;
    logic               b_seen;
    logic               c_seen;
    logic [31:0]        rd_value;
    mm_pkg::run_state_t state;

    // Only one response of each kind outstanding
    assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;
    assign rd_en     = s_arvalid && !s_rvalid;
    assign s_awready = wr_en;
    assign s_wready  = wr_en;
    assign s_arready = rd_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_bvalid  <= 1'b0;
            start_reg <= 1'b0;
            a_addr    <= '0;
            b_addr    <= '0;
            c_addr    <= '0;
        end else begin
            if (wr_en) begin
                s_bvalid <= 1'b1;
                case (s_awaddr)
                    `MM_REG_CTRL:   start_reg <= s_wdata[0];
                    `MM_REG_A_ADDR: a_addr <= s_wdata;
                    `MM_REG_B_ADDR: b_addr <= s_wdata;
                    `MM_REG_C_ADDR: c_addr <= s_wdata;
                    default: ;
                endcase
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    // Status bits come straight from the run state
    always_comb begin
        case (s_araddr)
            `MM_REG_CTRL: rd_value = {29'd0, state == mm_pkg::run_idle,
                                      state == mm_pkg::run_done, start_reg};
            `MM_REG_A_ADDR: rd_value = a_addr;
            `MM_REG_B_ADDR: rd_value = b_addr;
            `MM_REG_C_ADDR: rd_value = c_addr;
            default:        rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_rvalid <= 1'b0;
        end else if (rd_en) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_rdata <= rd_value;
        end
    end

    // DMA done pulses are kept until the next go
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= mm_pkg::run_idle;
            start_q   <= 1'b0;
            go        <= 1'b0;
            a_seen    <= 1'b0;
            b_seen    <= 1'b0;
            c_seen    <= 1'b0;
            interrupt <= 1'b0;
        end else begin
            start_q <= start_reg;
            go      <= 1'b0;
            if (a_done) begin
                a_seen <= 1'b1;
            end
            if (b_done) begin
                b_seen <= 1'b1;
            end
            if (c_done) begin
                c_seen <= 1'b1;
            end
            case (state)
                mm_pkg::run_idle: begin
                    if (start_reg && !start_q) begin
                        state  <= mm_pkg::run_running;
                        go     <= 1'b1;
                        a_seen <= 1'b0;
                        b_seen <= 1'b0;
                        c_seen <= 1'b0;
                    end
                end
                mm_pkg::run_running: begin
                    if (a_seen && b_seen && c_seen) begin
                        state     <= mm_pkg::run_done;
                        interrupt <= 1'b1;
                    end
                end
                mm_pkg::run_done: begin
                    // Host acknowledges by clearing start
                    if (!start_reg) begin
                        state     <= mm_pkg::run_idle;
                        interrupt <= 1'b0;
                    end
                end
                default: state <= mm_pkg::run_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/mm_mac_engine.sv
`default_nettype none

`include "mm_config.svh"

module mm_mac_engine (
    input  logic      clk,
    input  logic      rst,
    mm_beat_if.sink   a_rows,
    mm_beat_if.sink   b_rows,
    mm_beat_if.source c_rows
);

    localparam int idx_w = $clog2(`MM_DIM);

    mm_pkg::row_a_t   b_mem [`MM_DIM];
    mm_pkg::row_a_t   a_row;
    mm_pkg::row_c_t   acc;
    logic [idx_w-1:0] b_idx;
    logic [idx_w-1:0] k;
    logic             b_loaded;
    logic             computing;
    logic             c_valid;
    logic             row_last;

    // B fills first, then one A row at a time
    assign b_rows.ready = !b_loaded;
    assign a_rows.ready = b_loaded && !computing && !c_valid;

    assign c_rows.valid = c_valid;
    assign c_rows.data  = acc;
    assign c_rows.last  = c_valid && row_last;

    always_ff @(posedge clk) begin
        if (b_rows.valid && b_rows.ready) begin
            b_mem[b_idx] <= b_rows.data;
        end
    end

    // One k per cycle across all 16 columns
    always_ff @(posedge clk) begin
        if (a_rows.valid && a_rows.ready) begin
            a_row    <= a_rows.data;
            row_last <= a_rows.last;
            acc      <= '0;
        end else if (computing) begin
            for (int j = 0; j < `MM_DIM; j++) begin
                acc[j] <= acc[j] + a_row[k] * b_mem[k][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_idx     <= '0;
            b_loaded  <= 1'b0;
            k         <= '0;
            computing <= 1'b0;
            c_valid   <= 1'b0;
        end else begin
            if (b_rows.valid && b_rows.ready) begin
                b_idx <= b_idx + 1'b1;
                if (b_rows.last) begin
                    b_loaded <= 1'b1;
                end
            end
            if (a_rows.valid && a_rows.ready) begin
                computing <= 1'b1;
                k         <= '0;
            end else if (computing) begin
                k <= k + 1'b1;
                if (k == idx_w'(`MM_DIM - 1)) begin
                    computing <= 1'b0;
                    c_valid   <= 1'b1;
                end
            end
            if (c_valid && c_rows.ready) begin
                c_valid <= 1'b0;
                // Next run may bring a new B once the last row is gone
                if (row_last) begin
                    b_loaded <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mm_pkg.sv
`default_nettype none

`include "mm_config.svh"

package mm_pkg;

    // Operand element shared by A and B
    typedef logic signed [7:0] a_elem_t;

    // Result element that wraps to 16 bits
    typedef logic signed [15:0] c_elem_t;

    // One matrix row per beat with element k at byte k
    typedef a_elem_t [`MM_DIM-1:0] row_a_t;

    // Element j sits at halfword j
    typedef c_elem_t [`MM_DIM-1:0] row_c_t;

    typedef enum logic [1:0] {
        run_idle,
        run_running,
        run_done
    } run_state_t;

endpackage

`default_nettype wire

// File: source/mm_read_dma.sv
`default_nettype none

`include "mm_config.svh"

module mm_read_dma (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic [`MM_ADDR_W-1:0] base_addr,
    output logic                  ar_valid,
    output logic [`MM_ADDR_W-1:0] ar_addr,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  mm_pkg::row_a_t        r_data,
    input  logic                  r_last,
    output logic                  done,
    mm_beat_if.source             rows
);

    logic busy;

    // Memory holds r_data steady while stalled, so beats pass straight through
    assign rows.valid = busy && r_valid;
    assign rows.data  = r_data;
    assign rows.last  = r_last;
    assign r_ready    = busy && rows.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                ar_valid <= 1'b1;
                busy     <= 1'b1;
            end else if (ar_ready) begin
                ar_valid <= 1'b0;
            end
            if (r_valid && r_ready && r_last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            ar_addr <= base_addr;
        end
    end

endmodule

`default_nettype wire

// File: source/mm_top.sv
`default_nettype none

`include "mm_config.svh"

module mm_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s_awvalid,
    input  logic [`MM_REG_ADDR_W-1:0] s_awaddr,
    output logic                      s_awready,
    input  logic                      s_wvalid,
    input  logic [31:0]               s_wdata,
    output logic                      s_wready,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic                      s_arvalid,
    input  logic [`MM_REG_ADDR_W-1:0] s_araddr,
    output logic                      s_arready,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic [31:0]               s_rdata,
    output logic                      interrupt,
    output logic                      a_ar_valid,
    output logic [`MM_ADDR_W-1:0]     a_ar_addr,
    input  logic                      a_ar_ready,
    input  logic                      a_r_valid,
    output logic                      a_r_ready,
    input  mm_pkg::row_a_t            a_r_data,
    input  logic                      a_r_last,
    output logic                      b_ar_valid,
    output logic [`MM_ADDR_W-1:0]     b_ar_addr,
    input  logic                      b_ar_ready,
    input  logic                      b_r_valid,
    output logic                      b_r_ready,
    input  mm_pkg::row_a_t            b_r_data,
    input  logic                      b_r_last,
    output logic                      c_aw_valid,
    output logic [`MM_ADDR_W-1:0]     c_aw_addr,
    input  logic                      c_aw_ready,
    output logic                      c_w_valid,
    output mm_pkg::row_c_t            c_w_data,
    output logic                      c_w_last,
    input  logic                      c_w_ready,
    input  logic                      c_b_valid,
    output logic                      c_b_ready
);

    logic                  go;
    logic [`MM_ADDR_W-1:0] a_addr;
    logic [`MM_ADDR_W-1:0] b_addr;
    logic [`MM_ADDR_W-1:0] c_addr;
    logic                  a_done;
    logic                  b_done;
    logic                  c_done;

    mm_beat_if #(.payload_t(mm_pkg::row_a_t)) a_rows ();
    mm_beat_if #(.payload_t(mm_pkg::row_a_t)) b_rows ();
    mm_beat_if #(.payload_t(mm_pkg::row_c_t)) c_rows ();

    mm_control_regs regs (
        .clk(clk), .rst(rst),
        .s_awvalid(s_awvalid), .s_awaddr(s_awaddr), .s_awready(s_awready),
        .s_wvalid(s_wvalid), .s_wdata(s_wdata), .s_wready(s_wready),
        .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata),
        .a_done(a_done), .b_done(b_done), .c_done(c_done),
        .go(go), .a_addr(a_addr), .b_addr(b_addr), .c_addr(c_addr),
        .interrupt(interrupt)
    );

    mm_read_dma dma_a (
        .clk(clk), .rst(rst), .go(go), .base_addr(a_addr),
        .ar_valid(a_ar_valid), .ar_addr(a_ar_addr), .ar_ready(a_ar_ready),
        .r_valid(a_r_valid), .r_ready(a_r_ready), .r_data(a_r_data), .r_last(a_r_last),
        .done(a_done), .rows(a_rows)
    );

    mm_read_dma dma_b (
        .clk(clk), .rst(rst), .go(go), .base_addr(b_addr),
        .ar_valid(b_ar_valid), .ar_addr(b_ar_addr), .ar_ready(b_ar_ready),
        .r_valid(b_r_valid), .r_ready(b_r_ready), .r_data(b_r_data), .r_last(b_r_last),
        .done(b_done), .rows(b_rows)
    );

    mm_mac_engine engine (
        .clk(clk), .rst(rst),
        .a_rows(a_rows), .b_rows(b_rows), .c_rows(c_rows)
    );

    mm_write_dma dma_c (
        .clk(clk), .rst(rst), .go(go), .base_addr(c_addr),
        .aw_valid(c_aw_valid), .aw_addr(c_aw_addr), .aw_ready(c_aw_ready),
        .w_valid(c_w_valid), .w_data(c_w_data), .w_last(c_w_last), .w_ready(c_w_ready),
        .b_valid(c_b_valid), .b_ready(c_b_ready),
        .done(c_done), .rows(c_rows)
    );

endmodule

`default_nettype wire

// File: source/mm_write_dma.sv
`default_nettype none

`include "mm_config.svh"

module mm_write_dma (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic [`MM_ADDR_W-1:0] base_addr,
    output logic                  aw_valid,
    output logic [`MM_ADDR_W-1:0] aw_addr,
    input  logic                  aw_ready,
    output logic                  w_valid,
    output mm_pkg::row_c_t        w_data,
    output logic                  w_last,
    input  logic                  w_ready,
    input  logic                  b_valid,
    output logic                  b_ready,
    output logic                  done,
    mm_beat_if.sink               rows
);

    // High from go until the last beat has gone out
    logic fwd;

    assign w_valid    = fwd && rows.valid;
    assign w_data     = rows.data;
    assign w_last     = rows.last;
    assign rows.ready = fwd && w_ready;

    // Completion is the write response itself
    assign done = b_valid && b_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_valid <= 1'b0;
            fwd      <= 1'b0;
            b_ready  <= 1'b0;
        end else begin
            if (go) begin
                aw_valid <= 1'b1;
                fwd      <= 1'b1;
            end else if (aw_ready) begin
                aw_valid <= 1'b0;
            end
            if (w_valid && w_ready && w_last) begin
                fwd     <= 1'b0;
                b_ready <= 1'b1;
            end
            if (done) begin
                b_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            aw_addr <= base_addr;
        end
    end

endmodule

`default_nettype wire

// File: tb/mm_assertions.sv
`default_nettype none

`include "mm_config.svh"

module mm_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  a_ar_valid,
    input logic [`MM_ADDR_W-1:0] a_ar_addr,
    input logic                  a_ar_ready,
    input logic                  b_ar_valid,
    input logic [`MM_ADDR_W-1:0] b_ar_addr,
    input logic                  b_ar_ready,
    input logic                  c_aw_valid,
    input logic [`MM_ADDR_W-1:0] c_aw_addr,
    input logic                  c_aw_ready,
    input logic                  c_w_valid,
    input mm_pkg::row_c_t        c_w_data,
    input logic                  c_w_last,
    input logic                  c_w_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Requests stay up with a steady payload until taken
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        a_ar_valid && !a_ar_ready |=> a_ar_valid && $stable(a_ar_addr))
        else $error("A read request changed before ar_ready");

    b_ar_hold: assert property (@(posedge clk) disable iff (rst)
        b_ar_valid && !b_ar_ready |=> b_ar_valid && $stable(b_ar_addr))
        else $error("B read request changed before ar_ready");

    c_aw_hold: assert property (@(posedge clk) disable iff (rst)
        c_aw_valid && !c_aw_ready |=> c_aw_valid && $stable(c_aw_addr))
        else $error("C write request changed before aw_ready");

    c_w_hold: assert property (@(posedge clk) disable iff (rst)
        c_w_valid && !c_w_ready |=> c_w_valid && $stable(c_w_data) && $stable(c_w_last))
        else $error("C write beat changed before w_ready");

    c_last_valid: assert property (@(posedge clk) disable iff (rst)
        c_w_last |-> c_w_valid)
        else $error("c_w_last high without c_w_valid");

endmodule

`default_nettype wire

// File: tb/mm_clock_gen.sv
`default_nettype none

module mm_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for four cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/mm_stimulus.mem
// Lines 1 to 16 hold A rows and lines 17 to 32 hold B rows, byte k is column k
// Lines 33 to 48 hold the expected C rows, halfword j is column j
0f0e0d0c0b0a09080706050403020100
1f1e1d1c1b1a19181716151413121110
2f2e2d2c2b2a29282726252423222120
3f3e3d3c3b3a39383736353433323130
4f4e4d4c4b4a49484746454443424140
5f5e5d5c5b5a59585756555453525150
6f6e6d6c6b6a69686766656463626160
7f7e7d7c7b7a79787776757473727170
8f8e8d8c8b8a89888786858483828180
9f9e9d9c9b9a99989796959493929190
afaeadacabaaa9a8a7a6a5a4a3a2a1a0
bfbebdbcbbbab9b8b7b6b5b4b3b2b1b0
cfcecdcccbcac9c8c7c6c5c4c3c2c1c0
dfdedddcdbdad9d8d7d6d5d4d3d2d1d0
efeeedecebeae9e8e7e6e5e4e3e2e1e0
fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0
02
0200
020000
02000000
0200000000
020000000000
02000000000000
0200000000000000
020000000000000000
02000000000000000000
0200000000000000000000
020000000000000000000000
02000000000000000000000000
0200000000000000000000000000
020000000000000000000000000000
02000000000000000000000000000000
001e001c001a00180016001400120010000e000c000a00080006000400020000
003e003c003a00380036003400320030002e002c002a00280026002400220020
005e005c005a00580056005400520050004e004c004a00480046004400420040
007e007c007a00780076007400720070006e006c006a00680066006400620060
009e009c009a00980096009400920090008e008c008a00880086008400820080
00be00bc00ba00b800b600b400b200b000ae00ac00aa00a800a600a400a200a0
00de00dc00da00d800d600d400d200d000ce00cc00ca00c800c600c400c200c0
00fe00fc00fa00f800f600f400f200f000ee00ec00ea00e800e600e400e200e0
ff1eff1cff1aff18ff16ff14ff12ff10ff0eff0cff0aff08ff06ff04ff02ff00
ff3eff3cff3aff38ff36ff34ff32ff30ff2eff2cff2aff28ff26ff24ff22ff20
ff5eff5cff5aff58ff56ff54ff52ff50ff4eff4cff4aff48ff46ff44ff42ff40
ff7eff7cff7aff78ff76ff74ff72ff70ff6eff6cff6aff68ff66ff64ff62ff60
ff9eff9cff9aff98ff96ff94ff92ff90ff8eff8cff8aff88ff86ff84ff82ff80
ffbeffbcffbaffb8ffb6ffb4ffb2ffb0ffaeffacffaaffa8ffa6ffa4ffa2ffa0
ffdeffdcffdaffd8ffd6ffd4ffd2ffd0ffceffccffcaffc8ffc6ffc4ffc2ffc0
fffefffcfffafff8fff6fff4fff2fff0ffeeffecffeaffe8ffe6ffe4ffe2ffe0

// File: tb/mm_tb.sv
`default_nettype none

`include "mm_config.svh"

module mm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int beats = `MM_DIM;
    // Two runs of 48 beats at up to 40 cycles each, plus register traffic
    localparam int limit = 2 * (48 * 40) + 500;

    logic                      clk;
    logic                      rst;
    logic                      s_awvalid;
    logic [`MM_REG_ADDR_W-1:0] s_awaddr;
    logic                      s_awready;
    logic                      s_wvalid;
    logic [31:0]               s_wdata;
    logic                      s_wready;
    logic                      s_bvalid;
    logic                      s_bready;
    logic                      s_arvalid;
    logic [`MM_REG_ADDR_W-1:0] s_araddr;
    logic                      s_arready;
    logic                      s_rvalid;
    logic                      s_rready;
    logic [31:0]               s_rdata;
    logic                      interrupt;
    logic                      a_ar_valid;
    logic [`MM_ADDR_W-1:0]     a_ar_addr;
    logic                      a_ar_ready;
    logic                      a_r_valid;
    logic                      a_r_ready;
    mm_pkg::row_a_t            a_r_data;
    logic                      a_r_last;
    logic                      b_ar_valid;
    logic [`MM_ADDR_W-1:0]     b_ar_addr;
    logic                      b_ar_ready;
    logic                      b_r_valid;
    logic                      b_r_ready;
    mm_pkg::row_a_t            b_r_data;
    logic                      b_r_last;
    logic                      c_aw_valid;
    logic [`MM_ADDR_W-1:0]     c_aw_addr;
    logic                      c_aw_ready;
    logic                      c_w_valid;
    mm_pkg::row_c_t            c_w_data;
    logic                      c_w_last;
    logic                      c_w_ready;
    logic                      c_b_valid;
    logic                      c_b_ready;

    logic [255:0] stim [48];
    int           pass_count;
    int           fail_count;
    int           cycles;
    logic         stall_en = 1'b0;

    // Read side model where index 0 is A and index 1 is B
    logic [1:0]                        ar_ready_d;
    logic [1:0]                        r_valid_d;
    logic [1:0]                        r_last_d;
    mm_pkg::row_a_t [1:0]              r_data_d;
    logic [1:0]                        ar_valid_w;
    logic [1:0]                        r_ready_w;
    logic [1:0][`MM_ADDR_W-1:0]        ar_addr_w;
    logic [1:0]                        rd_active;
    logic [1:0]                        rd_taken;
    int                                rd_beats [2];
    logic [1:0][`MM_ADDR_W-1:0]        rd_addr_seen;

    // Write side model
    logic                  w_taken;
    logic                  b_taken;
    logic                  resp_due;
    logic [`MM_ADDR_W-1:0] c_addr_seen;
    mm_pkg::row_c_t        c_rows_got [$];
    logic                  c_last_got [$];

    assign a_ar_ready = ar_ready_d[0];
    assign a_r_valid  = r_valid_d[0];
    assign a_r_data   = r_data_d[0];
    assign a_r_last   = r_last_d[0];
    assign b_ar_ready = ar_ready_d[1];
    assign b_r_valid  = r_valid_d[1];
    assign b_r_data   = r_data_d[1];
    assign b_r_last   = r_last_d[1];
    assign ar_valid_w = {b_ar_valid, a_ar_valid};
    assign r_ready_w  = {b_r_ready, a_r_ready};
    assign ar_addr_w  = {b_ar_addr, a_ar_addr};

    mm_clock_gen clkgen (.clk(clk), .rst(rst));

    mm_top uut (.*);

    bind mm_top mm_assertions chk (.*);

    // Handshakes are seen on the rising edge
    always @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            rd_taken[ch] = r_valid_d[ch] && r_ready_w[ch];
            if (!rst && ar_valid_w[ch] && ar_ready_d[ch]) begin
                rd_addr_seen[ch] = ar_addr_w[ch];
                rd_active[ch]    = 1'b1;
                rd_beats[ch]     = 0;
            end
            if (rd_taken[ch]) begin
                rd_beats[ch]++;
                if (rd_beats[ch] == beats) begin
                    rd_active[ch] = 1'b0;
                end
            end
        end
        w_taken = c_w_valid && c_w_ready;
        b_taken = c_b_valid && c_b_ready;
        if (!rst && c_aw_valid && c_aw_ready) begin
            c_addr_seen = c_aw_addr;
        end
        if (w_taken) begin
            c_rows_got.push_back(c_w_data);
            c_last_got.push_back(c_w_last);
            if (c_w_last) begin
                resp_due = 1'b1;
            end
        end
    end

    // Memory answers on the falling edge
    initial begin
        void'($urandom(32'ha577));
        forever begin
            @(negedge clk);
            for (int ch = 0; ch < 2; ch++) begin
                ar_ready_d[ch] = !stall_en || ($urandom % 3 != 0);
                if (!(r_valid_d[ch] && !rd_taken[ch])) begin
                    if (rd_active[ch] && rd_beats[ch] < beats
                            && (!stall_en || $urandom % 3 != 0)) begin
                        r_valid_d[ch] = 1'b1;
                        r_data_d[ch]  = stim[ch * beats + rd_beats[ch]][127:0];
                        r_last_d[ch]  = rd_beats[ch] == beats - 1;
                    end else begin
                        r_valid_d[ch] = 1'b0;
                        r_last_d[ch]  = 1'b0;
                    end
                end
            end
            c_aw_ready = !stall_en || ($urandom % 3 != 0);
            c_w_ready  = !stall_en || ($urandom % 2 != 0);
            if (!(c_b_valid && !b_taken)) begin
                c_b_valid = resp_due;
                resp_due  = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the run never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act === exp) begin
            pass_count++;
            $display("ok    %s", name);
        end else begin
            fail_count++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_row(input string name, input mm_pkg::row_c_t exp,
                             input mm_pkg::row_c_t act);
        if (act === exp) begin
            pass_count++;
            $display("ok    %s", name);
        end else begin
            fail_count++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act === exp) begin
            pass_count++;
            $display("ok    %s", name);
        end else begin
            fail_count++;
            $display("error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic reg_write(input logic [`MM_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        s_awvalid = 1'b1;
        s_awaddr  = addr;
        s_wvalid  = 1'b1;
        s_wdata   = data;
        s_bready  = 1'b1;
        do @(posedge clk); while (!s_awready);
        // Address and data are taken in the same cycle
        check_flag($sformatf("wready with awready at %h", addr), 1'b1, s_wready);
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        do @(posedge clk); while (!s_bvalid);
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic reg_read(input logic [`MM_REG_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        s_arvalid = 1'b1;
        s_araddr  = addr;
        s_rready  = 1'b1;
        do @(posedge clk); while (!s_arready);
        @(negedge clk);
        s_arvalid = 1'b0;
        do @(posedge clk); while (!s_rvalid);
        data = s_rdata;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    // One full multiply, then the host acknowledge
    task automatic run_matrix(input string tag, input logic [31:0] a_base,
                              input logic [31:0] b_base, input logic [31:0] c_base);
        logic [31:0]    rd;
        mm_pkg::row_c_t exp_row;
        c_rows_got.delete();
        c_last_got.delete();
        reg_write(`MM_REG_A_ADDR, a_base);
        reg_write(`MM_REG_B_ADDR, b_base);
        reg_write(`MM_REG_C_ADDR, c_base);
        reg_write(`MM_REG_CTRL, 32'h1);
        while (!interrupt) @(posedge clk);
        @(negedge clk);
        check_word({tag, " a burst addr"}, a_base, rd_addr_seen[0]);
        check_word({tag, " b burst addr"}, b_base, rd_addr_seen[1]);
        check_word({tag, " c burst addr"}, c_base, c_addr_seen);
        check_word({tag, " c row count"}, beats, c_rows_got.size());
        for (int i = 0; i < beats && i < c_rows_got.size(); i++) begin
            exp_row = stim[2 * beats + i];
            check_row($sformatf("%s c row %0d", tag, i), exp_row, c_rows_got[i]);
            check_flag($sformatf("%s w_last %0d", tag, i), i == beats - 1, c_last_got[i]);
        end
        reg_read(`MM_REG_CTRL, rd);
        check_word({tag, " done status"}, 32'h3, rd);
        check_flag({tag, " interrupt high"}, 1'b1, interrupt);
        reg_write(`MM_REG_CTRL, 32'h0);
        reg_read(`MM_REG_CTRL, rd);
        check_word({tag, " idle status"}, 32'h4, rd);
        check_flag({tag, " interrupt low"}, 1'b0, interrupt);
    endtask

    initial begin
        logic [31:0] rd;
        s_awvalid = 1'b0;
        s_awaddr  = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        s_rready  = 1'b0;
        ar_ready_d = '0;
        r_valid_d  = '0;
        r_last_d   = '0;
        r_data_d   = '0;
        c_aw_ready = 1'b0;
        c_w_ready  = 1'b0;
        c_b_valid  = 1'b0;
        rd_active  = '0;
        rd_taken   = '0;
        rd_beats   = '{0, 0};
        resp_due   = 1'b0;
        w_taken    = 1'b0;
        b_taken    = 1'b0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        $readmemh("tb/mm_stimulus.mem", stim);

        @(posedge clk);
        while (rst) @(posedge clk);

        reg_read(`MM_REG_CTRL, rd);
        check_word("reset status", 32'h4, rd);
        check_flag("reset interrupt", 1'b0, interrupt);
        check_flag("reset a_ar_valid", 1'b0, a_ar_valid);
        check_flag("reset b_ar_valid", 1'b0, b_ar_valid);
        check_flag("reset c_aw_valid", 1'b0, c_aw_valid);
        check_flag("reset c_w_valid", 1'b0, c_w_valid);

        reg_write(`MM_REG_A_ADDR, 32'h1000_0000);
        reg_write(`MM_REG_B_ADDR, 32'h2000_0100);
        reg_write(`MM_REG_C_ADDR, 32'h3000_0200);
        reg_read(`MM_REG_A_ADDR, rd);
        check_word("a addr readback", 32'h1000_0000, rd);
        reg_read(`MM_REG_B_ADDR, rd);
        check_word("b addr readback", 32'h2000_0100, rd);
        reg_read(`MM_REG_C_ADDR, rd);
        check_word("c addr readback", 32'h3000_0200, rd);
        reg_read(6'h10, rd);
        check_word("unmapped read", 32'h0, rd);

        run_matrix("run1", 32'h1000_0000, 32'h2000_0100, 32'h3000_0200);

        // Second pass with random gaps on every channel
        stall_en = 1'b1;
        run_matrix("run2", 32'h4000_1000, 32'h5000_2000, 32'h6000_3000);

        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
